// ==== rab_cfg_pkg.sv ====
// RAB configuration package with AXI widths, field layout, vector types and FSM states
`default_nettype none

package rab_cfg_pkg;

  localparam int AXI_DATA_WIDTH  = 64;
  localparam int AXI_ADDR_WIDTH  = 32;
  localparam int AXI_STRB_WIDTH  = AXI_DATA_WIDTH / 8;
  localparam int ADDR_LSB        = 3;   // 64-bit registers
  localparam int ADDR_WIDTH_VIRT = 32;
  localparam int ADDR_WIDTH_PHYS = 40;
  localparam int N_FLAGS         = 4;
  localparam int MISS_ID_WIDTH   = 10;
  localparam int FIFO_EMPTY_BIT  = 63;  // Set in read data when the queue is empty

  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [AXI_STRB_WIDTH-1:0] axi_strb_t;
  typedef logic [ADDR_WIDTH_VIRT-1:0] virt_addr_t;
  typedef logic [MISS_ID_WIDTH-1:0] miss_id_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Field kind held by a register index, chosen by index modulo 4
  typedef enum logic [1:0] {
    FIELD_VIRT,
    FIELD_PHYS,
    FIELD_FLAGS
  } cfg_field_e;

  // B and R response sequencing
  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_VALID,
    RESP_DONE
  } resp_state_e;

endpackage

`default_nettype wire

// ==== cfg_wr_if.sv ====
// Config write interface carrying one committed AXI write to the register bank and miss queues
`timescale 1ns/1ps
`default_nettype none

interface cfg_wr_if;

  logic                  wr_en;    // Single-cycle commit pulse
  rab_cfg_pkg::axi_addr_t wr_addr;
  rab_cfg_pkg::axi_data_t wr_data;
  rab_cfg_pkg::axi_strb_t wr_strb;

  modport master (output wr_en, output wr_addr, output wr_data, output wr_strb);

  // Consumers take every pulse as there is no back-pressure
  modport slave (input wr_en, input wr_addr, input wr_data, input wr_strb);

endinterface

`default_nettype wire

// ==== sync_fifo.sv ====
// Sync FIFO with head output and full and empty flags, used for the miss queues
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = PTR_W + 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;   // Push on full is dropped
  assign do_pop  = pop && !empty;

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;       // Both or neither
      endcase
    end
  end

  assign dout  = mem[rd_ptr];  // Head of queue
  assign full  = (count == FULL_CNT);
  assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== axi_lite_slave.sv ====
// AXI4-Lite slave front end that captures writes, commits them and sequences B and R responses
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,

  input  rab_cfg_pkg::axi_addr_t     s_axi_awaddr,
  input  logic                       s_axi_awvalid,
  output logic                       s_axi_awready,
  input  rab_cfg_pkg::axi_data_t     s_axi_wdata,
  input  rab_cfg_pkg::axi_strb_t     s_axi_wstrb,
  input  logic                       s_axi_wvalid,
  output logic                       s_axi_wready,
  output rab_cfg_pkg::axi_resp_t     s_axi_bresp,
  output logic                       s_axi_bvalid,
  input  logic                       s_axi_bready,
  input  rab_cfg_pkg::axi_addr_t     s_axi_araddr,
  input  logic                       s_axi_arvalid,
  output logic                       s_axi_arready,
  output rab_cfg_pkg::axi_data_t     s_axi_rdata,
  output rab_cfg_pkg::axi_resp_t     s_axi_rresp,
  output logic                       s_axi_rvalid,
  input  logic                       s_axi_rready,

  cfg_wr_if.master                   wr,

  output rab_cfg_pkg::axi_addr_t     rd_addr,
  output logic                       rd_done,
  input  rab_cfg_pkg::axi_data_t     rdata
);

  rab_cfg_pkg::axi_addr_t    awaddr_q;
  rab_cfg_pkg::axi_data_t    wdata_q;
  rab_cfg_pkg::axi_strb_t    wstrb_q;
  rab_cfg_pkg::axi_addr_t    araddr_q;
  logic                      aw_held;
  logic                      w_held;
  logic                      ar_held;
  logic                      ar_seen;   // AR held for at least one full cycle
  logic                      commit;
  rab_cfg_pkg::resp_state_e  b_state;
  rab_cfg_pkg::resp_state_e  r_state;

  // Address and data are held until the response is done
  always_ff @(posedge Clk_CI)
  begin
    if (s_axi_awvalid && s_axi_awready)
    begin
      awaddr_q <= s_axi_awaddr;
    end
    if (s_axi_wvalid && s_axi_wready)
    begin
      wdata_q <= s_axi_wdata;
      wstrb_q <= s_axi_wstrb;
    end
    if (s_axi_arvalid && s_axi_arready)
    begin
      araddr_q <= s_axi_araddr;
    end
  end

  // AW and W taken independently and released one cycle after the B handshake
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      s_axi_awready <= 1'b1;
      s_axi_wready  <= 1'b1;
      aw_held       <= 1'b0;
      w_held        <= 1'b0;
    end
    else if (b_state == rab_cfg_pkg::RESP_DONE)
    begin
      s_axi_awready <= 1'b1;
      s_axi_wready  <= 1'b1;
      aw_held       <= 1'b0;
      w_held        <= 1'b0;
    end
    else
    begin
      if (s_axi_awvalid && s_axi_awready)
      begin
        s_axi_awready <= 1'b0;
        aw_held       <= 1'b1;
      end
      if (s_axi_wvalid && s_axi_wready)
      begin
        s_axi_wready <= 1'b0;
        w_held       <= 1'b1;
      end
    end
  end

  // Commit once both halves are in and raise bvalid on the same edge
  assign commit = aw_held && w_held && (b_state == rab_cfg_pkg::RESP_IDLE);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      b_state <= rab_cfg_pkg::RESP_IDLE;
    end
    else
    begin
      case (b_state)
        rab_cfg_pkg::RESP_IDLE:  if (commit) b_state <= rab_cfg_pkg::RESP_VALID;
        rab_cfg_pkg::RESP_VALID: if (s_axi_bready) b_state <= rab_cfg_pkg::RESP_DONE;
        default:                 b_state <= rab_cfg_pkg::RESP_IDLE;
      endcase
    end
  end

  // AR channel and R sequencing
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      s_axi_arready <= 1'b1;
      ar_held       <= 1'b0;
      ar_seen       <= 1'b0;
      r_state       <= rab_cfg_pkg::RESP_IDLE;
    end
    else
    begin
      ar_seen <= ar_held;
      if (s_axi_arvalid && s_axi_arready)
      begin
        s_axi_arready <= 1'b0;
        ar_held       <= 1'b1;
      end
      else if (r_state == rab_cfg_pkg::RESP_DONE)
      begin
        s_axi_arready <= 1'b1;
        ar_held       <= 1'b0;
      end
      case (r_state)
        rab_cfg_pkg::RESP_IDLE:  if (ar_held && ar_seen) r_state <= rab_cfg_pkg::RESP_VALID;
        rab_cfg_pkg::RESP_VALID: if (s_axi_rready) r_state <= rab_cfg_pkg::RESP_DONE;
        default:                 r_state <= rab_cfg_pkg::RESP_IDLE;
      endcase
    end
  end

  assign wr.wr_en   = commit;
  assign wr.wr_addr = awaddr_q;
  assign wr.wr_data = wdata_q;
  assign wr.wr_strb = wstrb_q;

  assign s_axi_bvalid = (b_state == rab_cfg_pkg::RESP_VALID);
  assign s_axi_bresp  = rab_cfg_pkg::RESP_OKAY;
  assign s_axi_rvalid = (r_state == rab_cfg_pkg::RESP_VALID);
  assign s_axi_rresp  = rab_cfg_pkg::RESP_OKAY;
  assign s_axi_rdata  = rdata;

  assign rd_addr = araddr_q;
  assign rd_done = s_axi_rvalid && s_axi_rready;  // Pops a miss queue head

endmodule

`default_nettype wire

// ==== l1_cfg_regs.sv ====
// L1 slice configuration register bank with byte strobes and per-field width masking
`timescale 1ns/1ps
`default_nettype none

module l1_cfg_regs #(
  parameter int N_REGS = 16
) (
  input  logic                                    Clk_CI,
  input  logic                                    Rst_RBI,
  cfg_wr_if.slave                                 wr,
  input  rab_cfg_pkg::axi_addr_t                  rd_addr,
  output rab_cfg_pkg::axi_data_t [N_REGS-1:0]     l1_cfg,
  output rab_cfg_pkg::axi_data_t                  l1_rdata
);

  localparam int IDX_W = (N_REGS > 1) ? $clog2(N_REGS) : 1;

  rab_cfg_pkg::axi_data_t [N_REGS-1:0] regs;
  rab_cfg_pkg::axi_data_t              wr_word;
  logic [IDX_W-1:0]                    wr_idx;
  logic [IDX_W-1:0]                    rd_idx;

  // Index modulo 4 picks the field kind
  function automatic rab_cfg_pkg::cfg_field_e field_of(input int unsigned idx);
    case (idx % 4)
      0, 1:    return rab_cfg_pkg::FIELD_VIRT;
      2:       return rab_cfg_pkg::FIELD_PHYS;
      default: return rab_cfg_pkg::FIELD_FLAGS;
    endcase
  endfunction

  function automatic rab_cfg_pkg::axi_data_t field_mask(input rab_cfg_pkg::cfg_field_e f);
    case (f)
      rab_cfg_pkg::FIELD_VIRT:
        return rab_cfg_pkg::axi_data_t'({rab_cfg_pkg::ADDR_WIDTH_VIRT{1'b1}});
      rab_cfg_pkg::FIELD_PHYS:
        return rab_cfg_pkg::axi_data_t'({rab_cfg_pkg::ADDR_WIDTH_PHYS{1'b1}});
      default:
        return rab_cfg_pkg::axi_data_t'({rab_cfg_pkg::N_FLAGS{1'b1}});
    endcase
  endfunction

  assign wr_idx = wr.wr_addr[rab_cfg_pkg::ADDR_LSB +: IDX_W];
  assign rd_idx = rd_addr[rab_cfg_pkg::ADDR_LSB +: IDX_W];

  // Unstrobed bytes are written as zero
  always_comb
  begin
    for (int b = 0; b < rab_cfg_pkg::AXI_STRB_WIDTH; b++)
    begin
      wr_word[8*b +: 8] = wr.wr_strb[b] ? wr.wr_data[8*b +: 8] : 8'h00;
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      regs <= '0;
    end
    else if (wr.wr_en && (int'(wr_idx) < N_REGS))
    begin
      regs[wr_idx] <= wr_word & field_mask(field_of(int'(wr_idx)));
    end
  end

  for (genvar i = 0; i < N_REGS; i++)
  begin : g_out
    assign l1_cfg[i] = regs[i] & field_mask(field_of(i));
  end

  assign l1_rdata = (int'(rd_idx) < N_REGS) ? l1_cfg[rd_idx] : '0;  // Out of range reads zero

endmodule

`default_nettype wire

// ==== miss_handler.sv ====
// Miss handler with address and ID queues, push arbitration and AXI read data selection
`timescale 1ns/1ps
`default_nettype none

module miss_handler #(
  parameter int MH_FIFO_DEPTH = 8,
  parameter int N_REGS        = 16
) (
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  cfg_wr_if.slave                 wr,
  input  rab_cfg_pkg::virt_addr_t miss_addr,
  input  rab_cfg_pkg::miss_id_t   miss_id,
  input  logic                    miss,
  input  rab_cfg_pkg::axi_addr_t  rd_addr,
  input  logic                    rd_done,
  input  rab_cfg_pkg::axi_data_t  l1_rdata,
  output rab_cfg_pkg::axi_data_t  rdata,
  output logic                    mh_fifo_full
);

  localparam int DEC_W = rab_cfg_pkg::ADDR_LSB + ((N_REGS > 1) ? $clog2(N_REGS) : 1);

  rab_cfg_pkg::virt_addr_t addr_din;
  rab_cfg_pkg::virt_addr_t addr_head;
  rab_cfg_pkg::miss_id_t   id_din;
  rab_cfg_pkg::miss_id_t   id_head;
  logic                    addr_push;
  logic                    id_push;
  logic                    addr_full;
  logic                    id_full;
  logic                    addr_empty;
  logic                    id_empty;
  logic                    wr_sel_addr;
  logic                    wr_sel_id;
  logic                    rd_sel_addr;
  logic                    rd_sel_id;

  assign wr_sel_addr = (wr.wr_addr[DEC_W-1:0] == DEC_W'(8'h00));
  assign wr_sel_id   = (wr.wr_addr[DEC_W-1:0] == DEC_W'(8'h08));
  assign rd_sel_addr = (rd_addr[DEC_W-1:0] == DEC_W'(8'h00));
  assign rd_sel_id   = (rd_addr[DEC_W-1:0] == DEC_W'(8'h08));

  // Miss strobe has priority over software pushes
  always_comb
  begin
    addr_push = miss || (wr.wr_en && wr_sel_addr);
    id_push   = miss || (wr.wr_en && wr_sel_id);
    addr_din  = miss ? miss_addr : wr.wr_data[rab_cfg_pkg::ADDR_WIDTH_VIRT-1:0];
    id_din    = miss ? miss_id : wr.wr_data[rab_cfg_pkg::MISS_ID_WIDTH-1:0];
  end

  assign mh_fifo_full = (addr_push && addr_full) || (id_push && id_full);

  always_comb
  begin
    rdata = l1_rdata;
    if (rd_sel_addr)
    begin
      rdata = '0;
      rdata[rab_cfg_pkg::FIFO_EMPTY_BIT] = addr_empty;
      rdata[rab_cfg_pkg::ADDR_WIDTH_VIRT-1:0] = addr_head;
    end
    else if (rd_sel_id)
    begin
      rdata = '0;
      rdata[rab_cfg_pkg::FIFO_EMPTY_BIT] = id_empty;
      rdata[rab_cfg_pkg::MISS_ID_WIDTH-1:0] = id_head;
    end
  end

  sync_fifo #(.WIDTH(rab_cfg_pkg::ADDR_WIDTH_VIRT), .DEPTH(MH_FIFO_DEPTH)) u_addr_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push    (addr_push),
    .din     (addr_din),
    .pop     (rd_done && rd_sel_addr && !addr_empty),
    .dout    (addr_head),
    .full    (addr_full),
    .empty   (addr_empty)
  );

  sync_fifo #(.WIDTH(rab_cfg_pkg::MISS_ID_WIDTH), .DEPTH(MH_FIFO_DEPTH)) u_id_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push    (id_push),
    .din     (id_din),
    .pop     (rd_done && rd_sel_id && !id_empty),
    .dout    (id_head),
    .full    (id_full),
    .empty   (id_empty)
  );

endmodule

`default_nettype wire

// ==== axi_rab_cfg.sv ====
// RAB configuration top with AXI4-Lite slave, L1 register bank and miss queues
`timescale 1ns/1ps
`default_nettype none

module axi_rab_cfg #(
  parameter int N_REGS        = 16,
  parameter int MH_FIFO_DEPTH = 8
) (
  input  logic                                 Clk_CI,
  input  logic                                 Rst_RBI,

  input  rab_cfg_pkg::axi_addr_t               s_axi_awaddr,
  input  logic                                 s_axi_awvalid,
  output logic                                 s_axi_awready,
  input  rab_cfg_pkg::axi_data_t               s_axi_wdata,
  input  rab_cfg_pkg::axi_strb_t               s_axi_wstrb,
  input  logic                                 s_axi_wvalid,
  output logic                                 s_axi_wready,
  output rab_cfg_pkg::axi_resp_t               s_axi_bresp,
  output logic                                 s_axi_bvalid,
  input  logic                                 s_axi_bready,
  input  rab_cfg_pkg::axi_addr_t               s_axi_araddr,
  input  logic                                 s_axi_arvalid,
  output logic                                 s_axi_arready,
  output rab_cfg_pkg::axi_data_t               s_axi_rdata,
  output rab_cfg_pkg::axi_resp_t               s_axi_rresp,
  output logic                                 s_axi_rvalid,
  input  logic                                 s_axi_rready,

  output rab_cfg_pkg::axi_data_t [N_REGS-1:0]  l1_cfg,

  input  rab_cfg_pkg::virt_addr_t              miss_addr,
  input  rab_cfg_pkg::miss_id_t                miss_id,
  input  logic                                 miss,
  output logic                                 mh_fifo_full
);

  rab_cfg_pkg::axi_addr_t rd_addr;
  rab_cfg_pkg::axi_data_t l1_rdata;
  rab_cfg_pkg::axi_data_t rdata;
  logic                   rd_done;

  cfg_wr_if wr ();

  axi_lite_slave u_slave (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .wr            (wr.master),
    .rd_addr       (rd_addr),
    .rd_done       (rd_done),
    .rdata         (rdata)
  );

  l1_cfg_regs #(.N_REGS(N_REGS)) u_l1_regs (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .wr       (wr.slave),
    .rd_addr  (rd_addr),
    .l1_cfg   (l1_cfg),
    .l1_rdata (l1_rdata)
  );

  miss_handler #(.MH_FIFO_DEPTH(MH_FIFO_DEPTH), .N_REGS(N_REGS)) u_miss (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .wr           (wr.slave),
    .miss_addr    (miss_addr),
    .miss_id      (miss_id),
    .miss         (miss),
    .rd_addr      (rd_addr),
    .rd_done      (rd_done),
    .l1_rdata     (l1_rdata),
    .rdata        (rdata),
    .mh_fifo_full (mh_fifo_full)
  );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Testbench clock source with a fixed period
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic Clk_CI
);

  initial
  begin
    Clk_CI = 1'b0;
    forever #(PERIOD_NS / 2) Clk_CI = ~Clk_CI;
  end

endmodule

`default_nettype wire

// ==== tb_axi_rab_cfg.sv ====
// Testbench for the RAB config block, covering L1 register access and the miss queues over AXI
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rab_cfg;

  localparam int N_REGS        = 16;
  localparam int MH_FIFO_DEPTH = 8;
  localparam int CLK_PERIOD    = 40;
  localparam int N_PARTIAL     = 4;
  localparam int N_MISS        = 5;
  // AXI writes and reads issued over all tests
  localparam int N_TRANS = 2 * (N_REGS - 2) + 2 * N_PARTIAL + (2 * MH_FIFO_DEPTH + 2)
                         + (2 * N_MISS + 2) + 6;

  logic                                Clk_CI;
  logic                                Rst_RBI;
  rab_cfg_pkg::axi_addr_t              s_axi_awaddr;
  logic                                s_axi_awvalid;
  logic                                s_axi_awready;
  rab_cfg_pkg::axi_data_t              s_axi_wdata;
  rab_cfg_pkg::axi_strb_t              s_axi_wstrb;
  logic                                s_axi_wvalid;
  logic                                s_axi_wready;
  rab_cfg_pkg::axi_resp_t              s_axi_bresp;
  logic                                s_axi_bvalid;
  logic                                s_axi_bready;
  rab_cfg_pkg::axi_addr_t              s_axi_araddr;
  logic                                s_axi_arvalid;
  logic                                s_axi_arready;
  rab_cfg_pkg::axi_data_t              s_axi_rdata;
  rab_cfg_pkg::axi_resp_t              s_axi_rresp;
  logic                                s_axi_rvalid;
  logic                                s_axi_rready;
  rab_cfg_pkg::axi_data_t [N_REGS-1:0] l1_cfg;
  rab_cfg_pkg::virt_addr_t             miss_addr;
  rab_cfg_pkg::miss_id_t               miss_id;
  logic                                miss;
  logic                                mh_fifo_full;

  logic [63:0]             rng = 64'd19694;
  string                   test_name;
  rab_cfg_pkg::virt_addr_t exp_addr [$];  // Expected miss queue contents
  rab_cfg_pkg::miss_id_t   exp_id [$];

  tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.Clk_CI(Clk_CI));

  axi_rab_cfg #(.N_REGS(N_REGS), .MH_FIFO_DEPTH(MH_FIFO_DEPTH)) UUT (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .l1_cfg        (l1_cfg),
    .miss_addr     (miss_addr),
    .miss_id       (miss_id),
    .miss          (miss),
    .mh_fifo_full  (mh_fifo_full)
  );

  function automatic logic [63:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 7);
    rng = rng ^ (rng << 17);
    return rng;
  endfunction

  // Strobed bytes kept, then cut to the field width of the index
  function automatic rab_cfg_pkg::axi_data_t expected_word(input int idx,
      input rab_cfg_pkg::axi_data_t data, input rab_cfg_pkg::axi_strb_t strb);
    rab_cfg_pkg::axi_data_t word;
    int                     width;
    word = '0;
    for (int b = 0; b < 8; b++)
    begin
      if (strb[b])
      begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    case (idx % 4)
      0, 1:    width = 32;
      2:       width = 40;
      default: width = 4;   // Flags
    endcase
    return word & ((64'd1 << width) - 64'd1);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what, input rab_cfg_pkg::axi_data_t exp_val,
      input rab_cfg_pkg::axi_data_t act_val);
    report_failure($sformatf("ERR %s %s expected 0x%016h actual 0x%016h",
                             test_name, what, exp_val, act_val));
  endtask

  task automatic check_value(input string what, input rab_cfg_pkg::axi_data_t exp_val,
      input rab_cfg_pkg::axi_data_t act_val);
    assert (act_val === exp_val)
    else report_mismatch(what, exp_val, act_val);
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic axi_write(input rab_cfg_pkg::axi_addr_t addr,
      input rab_cfg_pkg::axi_data_t data, input rab_cfg_pkg::axi_strb_t strb);
    logic aw_pend;
    logic w_pend;
    logic aw_hs;
    logic w_hs;
    s_axi_awaddr  = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_wvalid  = 1'b1;
    aw_pend       = 1'b1;
    w_pend        = 1'b1;
    while (aw_pend || w_pend)
    begin
      aw_hs = aw_pend && s_axi_awready;  // Ready is registered, so the next edge takes it
      w_hs  = w_pend && s_axi_wready;
      @(negedge Clk_CI);
      if (aw_hs)
      begin
        s_axi_awvalid = 1'b0;
        aw_pend       = 1'b0;
      end
      if (w_hs)
      begin
        s_axi_wvalid = 1'b0;
        w_pend       = 1'b0;
      end
    end
    while (!s_axi_bvalid)
    begin
      @(negedge Clk_CI);
    end
    check_value("bresp", rab_cfg_pkg::RESP_OKAY, s_axi_bresp);
    @(negedge Clk_CI);    // One stalled cycle on B
    s_axi_bready = 1'b1;
    @(negedge Clk_CI);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input rab_cfg_pkg::axi_addr_t addr,
      output rab_cfg_pkg::axi_data_t data);
    logic hs;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    hs            = 1'b0;
    while (!hs)
    begin
      hs = s_axi_arready;
      @(negedge Clk_CI);
    end
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid)
    begin
      @(negedge Clk_CI);
    end
    @(negedge Clk_CI);    // One stalled cycle on R
    data = s_axi_rdata;
    check_value("rresp", rab_cfg_pkg::RESP_OKAY, s_axi_rresp);
    s_axi_rready = 1'b1;
    @(negedge Clk_CI);
    s_axi_rready = 0;
  endtask

  // Pops count entries from each queue in order, then both must report empty
  task automatic drain_miss_queues(input int count);
    rab_cfg_pkg::axi_data_t rd;
    for (int n = 0; n < count; n++)
    begin
      axi_read(32'h00, rd);
      check_value($sformatf("miss addr %0d", n),
                  rab_cfg_pkg::axi_data_t'(exp_addr.pop_front()), rd);
      axi_read(32'h08, rd);
      check_value($sformatf("miss id %0d", n), rab_cfg_pkg::axi_data_t'(exp_id.pop_front()), rd);
    end
    axi_read(32'h00, rd);
    check_value("addr queue empty bit", 1, rd[rab_cfg_pkg::FIFO_EMPTY_BIT]);
    axi_read(32'h08, rd);
    check_value("id queue empty bit", 1, rd[rab_cfg_pkg::FIFO_EMPTY_BIT]);
  endtask

  r_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (s_axi_rvalid && !s_axi_rready) |=> (s_axi_rvalid && $stable(s_axi_rdata)))
  else report_failure("R channel dropped rvalid or changed rdata while stalled");

  b_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
  else report_failure("B channel dropped bvalid while stalled");

  // Watchdog sized from the AXI transaction count
  initial
  begin
    repeat (N_TRANS * 200 + 10) @(posedge Clk_CI);
    report_failure($sformatf("Timeout after %0d AXI transactions worth of cycles", N_TRANS));
  end

  initial
  begin
    rab_cfg_pkg::axi_data_t data;
    rab_cfg_pkg::axi_data_t exp;
    rab_cfg_pkg::axi_data_t rd;
    rab_cfg_pkg::axi_strb_t strb;
    int                     idx;
    Rst_RBI       = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    miss_addr     = '0;
    miss_id       = '0;
    miss          = 1'b0;

    test_name = "reset";
    repeat (3) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);
    check_value("awready", 1, s_axi_awready);
    check_value("wready", 1, s_axi_wready);
    check_value("arready", 1, s_axi_arready);
    check_value("bvalid", 0, s_axi_bvalid);
    check_value("rvalid", 0, s_axi_rvalid);
    check_value("mh_fifo_full", 0, mh_fifo_full);
    for (int i = 0; i < N_REGS; i++)
    begin
      check_value($sformatf("l1_cfg[%0d]", i), '0, l1_cfg[i]);
    end

    test_name = "l1_full_strobe";
    for (int i = 2; i < N_REGS; i++)
    begin
      data = next_rand();
      exp  = expected_word(i, data, 8'hFF);
      axi_write(rab_cfg_pkg::axi_addr_t'(i) << rab_cfg_pkg::ADDR_LSB, data, 8'hFF);
      check_value($sformatf("l1_cfg[%0d]", i), exp, l1_cfg[i]);
      axi_read(rab_cfg_pkg::axi_addr_t'(i) << rab_cfg_pkg::ADDR_LSB, rd);
      check_value($sformatf("read index %0d", i), exp, rd);
    end

    test_name = "l1_partial_strobe";
    for (int n = 0; n < N_PARTIAL; n++)
    begin
      idx  = 2 + int'(next_rand() % (N_REGS - 2));  // Keeps clear of the queue addresses
      data = next_rand();
      strb = rab_cfg_pkg::axi_strb_t'(next_rand());
      if (strb == 8'hFF)
      begin
        strb = 8'h5A;
      end
      exp = expected_word(idx, data, strb);
      axi_write(rab_cfg_pkg::axi_addr_t'(idx) << rab_cfg_pkg::ADDR_LSB, data, strb);
      check_value($sformatf("l1_cfg[%0d]", idx), exp, l1_cfg[idx]);
      axi_read(rab_cfg_pkg::axi_addr_t'(idx) << rab_cfg_pkg::ADDR_LSB, rd);
      check_value($sformatf("read index %0d", idx), exp, rd);
    end

    // Fills every entry first so later empty reads show written data
    test_name = "fifo_overflow";
    for (int n = 0; n <= MH_FIFO_DEPTH; n++)
    begin
      miss_addr = rab_cfg_pkg::virt_addr_t'(next_rand());
      miss_id   = rab_cfg_pkg::miss_id_t'(next_rand());
      miss      = 1'b1;
      if (n < MH_FIFO_DEPTH)
      begin
        exp_addr.push_back(miss_addr);
        exp_id.push_back(miss_id);
      end
      #(CLK_PERIOD / 4);
      check_value($sformatf("mh_fifo_full on push %0d", n + 1), n == MH_FIFO_DEPTH,
                  mh_fifo_full);
      @(negedge Clk_CI);
    end
    miss = 1'b0;
    drain_miss_queues(MH_FIFO_DEPTH);

    test_name = "miss_order";
    for (int n = 0; n < N_MISS; n++)
    begin
      miss_addr = rab_cfg_pkg::virt_addr_t'(next_rand());
      miss_id   = rab_cfg_pkg::miss_id_t'(next_rand());
      miss      = 1'b1;
      exp_addr.push_back(miss_addr);
      exp_id.push_back(miss_id);
      @(negedge Clk_CI);
    end
    miss = 1'b0;
    drain_miss_queues(N_MISS);

    test_name = "axi_push";
    data = next_rand();
    axi_write(32'h00, data, 8'hFF);
    check_value("l1_cfg[0]", expected_word(0, data, 8'hFF), l1_cfg[0]);  // Also lands in L1
    exp_addr.push_back(rab_cfg_pkg::virt_addr_t'(data));
    data = next_rand();
    axi_write(32'h08, data, 8'hFF);
    check_value("l1_cfg[1]", expected_word(1, data, 8'hFF), l1_cfg[1]);
    exp_id.push_back(rab_cfg_pkg::miss_id_t'(data));
    drain_miss_queues(1);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rab_cfg_pkg.sv
cfg_wr_if.sv
sync_fifo.sv
axi_lite_slave.sv
l1_cfg_regs.sv
miss_handler.sv
axi_rab_cfg.sv
tb_clock.sv
tb_axi_rab_cfg.sv

// ==== Makefile ====
# Verilator build and run for the RAB configuration block

VERILATOR ?= verilator
TOP       ?= tb_axi_rab_cfg
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
